//--- Bender.yml
package:
  name: imuldiv

sources:
  # package and interface come first
  - rtl/imuldiv_pkg.sv
  - rtl/imuldiv_step_if.sv
  - rtl/imuldiv_ctrl.sv
  - rtl/imuldiv_mul_dpath.sv
  - rtl/imuldiv_div_dpath.sv
  - rtl/imuldiv_top.sv
  - target: test
    files:
      - tests/imuldiv_tb.sv

//--- imuldiv.f
rtl/imuldiv_pkg.sv
rtl/imuldiv_step_if.sv
rtl/imuldiv_ctrl.sv
rtl/imuldiv_mul_dpath.sv
rtl/imuldiv_div_dpath.sv
rtl/imuldiv_top.sv
tests/imuldiv_tb.sv

//--- rtl/imuldiv_ctrl.sv
/* Wishbone classic slave with one operation in flight. a command written while busy is
   acked and dropped; result reads while busy are held off until the operation is done */
`timescale 1ns/1ps

module imuldiv_ctrl (
  input  logic               clk,
  input  logic               reset,
  input  logic               wb_cyc,
  input  logic               wb_stb,
  input  logic               wb_we,
  input  imuldiv_pkg::addr_t wb_adr,
  input  imuldiv_pkg::word_t wb_wdata,
  output imuldiv_pkg::word_t wb_rdata,
  output logic               wb_ack,
  imuldiv_step_if.ctrl       mul,
  imuldiv_step_if.ctrl       div
);
  import imuldiv_pkg::*;

  word_t       a_q;
  word_t       b_q;
  op_t         op_q;
  state_t      state_q;
  step_count_t count_q;
  logic        load_q;
  logic        req;
  logic        res_read;
  logic        busy;
  logic        stall;
  logic        is_div;
  logic        is_signed;
  logic        calc;
  dword_t      result;

  // ----------------------------------------------------------
  // request decode
  // ----------------------------------------------------------
  // no new request during the ack cycle while the master still holds stb
  assign req      = wb_cyc && wb_stb && !wb_ack;
  assign res_read = !wb_we && ((wb_adr == adr_res_lo) || (wb_adr == adr_res_hi));
  // load cycle counts as busy so status never shows a gap
  assign busy     = load_q || (state_q == st_calc);
  assign stall    = res_read && busy;

  assign is_div    = (op_q == op_div) || (op_q == op_divu);
  assign is_signed = (op_q == op_mul) || (op_q == op_div);
  assign calc      = (state_q == st_calc);
  assign result    = is_div ? div.result : mul.result;

  // bus registers, ack and registered read data
  always_ff @(posedge clk) begin
    if (reset) begin
      wb_ack   <= 1'b0;
      wb_rdata <= '0;
      a_q      <= '0;
      b_q      <= '0;
      op_q     <= op_mul;
      load_q   <= 1'b0;
    end else begin
      wb_ack <= req && !stall;
      load_q <= 1'b0;
      if (req && !stall) begin
        if (wb_we) begin
          case (wb_adr)
            adr_a: a_q <= wb_wdata;
            adr_b: b_q <= wb_wdata;
            adr_cmd: begin
              // dropped while an operation is running
              if (!busy) begin
                op_q   <= op_t'(wb_wdata[1:0]);
                load_q <= 1'b1;
              end
            end
            default: ;
          endcase
        end else begin
          case (wb_adr)
            adr_a:      wb_rdata <= a_q;
            adr_b:      wb_rdata <= b_q;
            adr_cmd:    wb_rdata <= word_t'(op_q);
            adr_res_lo: wb_rdata <= result[31:0];
            adr_res_hi: wb_rdata <= result[63:32];
            adr_status: wb_rdata <= word_t'(busy);
            default:    wb_rdata <= '0;
          endcase
        end
      end
    end
  end

  // ----------------------------------------------------------
  // sequencer
  // ----------------------------------------------------------
  // calc lasts num_steps cycles as the counter runs down to zero
  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= st_idle;
      count_q <= '0;
    end else begin
      case (state_q)
        st_idle, st_done: begin
          if (load_q) begin
            state_q <= st_calc;
            count_q <= step_count_t'(num_steps - 1);
          end
        end
        st_calc: begin
          if (count_q == '0) state_q <= st_done;
          else count_q <= count_q - 1'b1;
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  // steer load and step to the datapath picked by the command
  assign mul.load      = load_q && !is_div;
  assign div.load      = load_q && is_div;
  assign mul.step      = calc && !is_div;
  assign div.step      = calc && is_div;
  assign mul.operand_a = a_q;
  assign mul.operand_b = b_q;
  assign mul.is_signed = is_signed;
  assign div.operand_a = a_q;
  assign div.operand_b = b_q;
  assign div.is_signed = is_signed;

  // ----------------------------------------------------------
  // checks
  // ----------------------------------------------------------
  a_ack_needs_req: assert property (@(posedge clk) disable iff (reset)
    $rose(wb_ack) |-> $past(wb_cyc && wb_stb));
  a_no_step_idle: assert property (@(posedge clk) disable iff (reset)
    (state_q == st_idle) && !load_q |=> !(mul.step || div.step));
  a_load_step_excl: assert property (@(posedge clk) disable iff (reset)
    !((mul.load || div.load) && (mul.step || div.step)));

endmodule

//--- rtl/imuldiv_div_dpath.sv
/* restoring divider on magnitudes. quotient sign is the xor of the operand signs,
   remainder sign follows the dividend; divide by zero gives all ones and the dividend */
`timescale 1ns/1ps

module imuldiv_div_dpath (
  input logic           clk,
  input logic           reset,
  imuldiv_step_if.dpath port
);
  import imuldiv_pkg::*;

  word_t        mag_a;
  word_t        mag_b;
  word_t        divisor_q;
  dword_t       rq_q;
  logic         quo_neg_q;
  logic         rem_neg_q;
  logic         div_zero_q;
  logic [33:0]  diff;
  word_t        quo;
  word_t        rem;

  // ----------------------------------------------------------
  // operand magnitudes
  // ----------------------------------------------------------
  assign mag_a = (port.is_signed && port.operand_a[31]) ? -port.operand_a
                                                        : port.operand_a;
  assign mag_b = (port.is_signed && port.operand_b[31]) ? -port.operand_b
                                                        : port.operand_b;

  // trial subtract on the remainder shifted left by one
  // the shifted remainder can reach 33 bits, so the compare is 34 wide
  assign diff = {1'b0, rq_q[63:31]} - {2'b0, divisor_q};

  // remainder:quotient pair and flags
  always_ff @(posedge clk) begin
    if (reset) begin
      rq_q       <= '0;
      quo_neg_q  <= 1'b0;
      rem_neg_q  <= 1'b0;
      div_zero_q <= 1'b0;
    end else if (port.load) begin
      rq_q       <= {32'b0, mag_a};
      quo_neg_q  <= port.is_signed && (port.operand_a[31] ^ port.operand_b[31]);
      rem_neg_q  <= port.is_signed && port.operand_a[31];
      div_zero_q <= (port.operand_b == '0);
    end else if (port.step) begin
      // keep a non-negative difference and set the quotient bit
      if (!diff[33]) rq_q <= {diff[31:0], rq_q[30:0], 1'b1};
      else rq_q <= {rq_q[62:0], 1'b0};
    end
  end

  // divisor stays fixed for the whole operation
  always_ff @(posedge clk) begin
    if (port.load) divisor_q <= mag_b;
  end

  // ----------------------------------------------------------
  // sign correction
  // ----------------------------------------------------------
  // with a zero divisor every trial succeeds and the remainder ends up
  // holding the dividend magnitude, so only the quotient needs forcing
  assign quo = div_zero_q ? '1 : (quo_neg_q ? -rq_q[31:0] : rq_q[31:0]);
  assign rem = rem_neg_q ? -rq_q[63:32] : rq_q[63:32];

  // remainder in the high word, quotient in the low word
  assign port.result = {rem, quo};

  // operands must be settled before the first iteration
  a_no_step_on_load: assert property (@(posedge clk) disable iff (reset)
    port.load |-> !port.step);

endmodule

//--- rtl/imuldiv_mul_dpath.sv
/* shift-and-add multiplier on operand magnitudes, 32 steps after a load.
   the sign is fixed up combinationally on the way out */
`timescale 1ns/1ps

module imuldiv_mul_dpath (
  input logic           clk,
  input logic           reset,
  imuldiv_step_if.dpath port
);
  import imuldiv_pkg::*;

  word_t  mag_a;
  word_t  mag_b;
  dword_t mcand_q;
  word_t  mplier_q;
  dword_t acc_q;
  logic   neg_q;

  // ----------------------------------------------------------
  // operand magnitudes
  // ----------------------------------------------------------
  // the most negative input maps onto 32'h8000_0000 and stays exact as unsigned
  assign mag_a = (port.is_signed && port.operand_a[31]) ? -port.operand_a
                                                        : port.operand_a;
  assign mag_b = (port.is_signed && port.operand_b[31]) ? -port.operand_b
                                                        : port.operand_b;

  // accumulator and product sign
  always_ff @(posedge clk) begin
    if (reset) begin
      acc_q <= '0;
      neg_q <= 1'b0;
    end else if (port.load) begin
      acc_q <= '0;
      neg_q <= port.is_signed && (port.operand_a[31] ^ port.operand_b[31]);
    end else if (port.step) begin
      // add the shifted multiplicand for each set multiplier bit
      if (mplier_q[0]) acc_q <= acc_q + mcand_q;
    end
  end

  // ----------------------------------------------------------
  // shift registers
  // ----------------------------------------------------------
  // multiplicand moves left and multiplier moves right by one bit per step
  always_ff @(posedge clk) begin
    if (port.load) begin
      mcand_q  <= {32'b0, mag_a};
      mplier_q <= mag_b;
    end else if (port.step) begin
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  // negate the magnitude product when exactly one operand was negative
  assign port.result = neg_q ? -acc_q : acc_q;

endmodule

//--- rtl/imuldiv_pkg.sv
/* shared widths, Wishbone register map and state encodings of the multiply/divide unit.
   word addresses only; byte lanes are not supported */
package imuldiv_pkg;

  // ----------------------------------------------------------
  // data widths
  // ----------------------------------------------------------
  typedef logic [31:0] word_t;
  // product, or remainder in the upper half and quotient in the lower
  typedef logic [63:0] dword_t;
  typedef logic [4:0]  step_count_t;
  typedef logic [2:0]  addr_t;

  // one shift step per operand bit
  localparam int num_steps = 32;

  // ----------------------------------------------------------
  // register map
  // ----------------------------------------------------------
  localparam addr_t adr_a      = 3'd0;
  localparam addr_t adr_b      = 3'd1;
  // a write here starts the operation
  localparam addr_t adr_cmd    = 3'd2;
  localparam addr_t adr_res_lo = 3'd3;
  localparam addr_t adr_res_hi = 3'd4;
  // bit 0 is busy
  localparam addr_t adr_status = 3'd5;

  // command register low bits
  typedef enum logic [1:0] {
    op_mul  = 2'd0,
    op_mulu = 2'd1,
    op_div  = 2'd2,
    op_divu = 2'd3
  } op_t;

  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_done = 2'd2
  } state_t;

endpackage

//--- rtl/imuldiv_step_if.sv
/* control to datapath link. load is a single cycle, step runs one iteration per cycle,
   and result holds from the cycle after the last step until the next load */
`timescale 1ns/1ps

interface imuldiv_step_if;
  import imuldiv_pkg::*;

  // capture operands, one cycle
  logic   load;
  // advance one iteration
  logic   step;
  word_t  operand_a;
  word_t  operand_b;
  // treat operands as two's complement
  logic   is_signed;
  // combinational from datapath registers
  dword_t result;

  modport ctrl (
    output load,
    output step,
    output operand_a,
    output operand_b,
    output is_signed,
    input  result
  );

  modport dpath (
    input  load,
    input  step,
    input  operand_a,
    input  operand_b,
    input  is_signed,
    output result
  );

endinterface

//--- rtl/imuldiv_top.sv
/* iterative multiply/divide unit as a Wishbone classic slave.
   no bursts, err or rty; one operation at a time */
`timescale 1ns/1ps

module imuldiv_top (
  input  logic               clk,
  input  logic               reset,
  input  logic               wb_cyc,
  input  logic               wb_stb,
  input  logic               wb_we,
  input  imuldiv_pkg::addr_t wb_adr,
  input  imuldiv_pkg::word_t wb_wdata,
  output imuldiv_pkg::word_t wb_rdata,
  output logic               wb_ack
);

  // one link per datapath
  imuldiv_step_if mul_bus ();
  imuldiv_step_if div_bus ();

  // bus registers and sequencing
  imuldiv_ctrl ctrl (
    .clk      (clk),
    .reset    (reset),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_wdata (wb_wdata),
    .wb_rdata (wb_rdata),
    .wb_ack   (wb_ack),
    .mul      (mul_bus.ctrl),
    .div      (div_bus.ctrl)
  );

  // ----------------------------------------------------------
  // datapaths
  // ----------------------------------------------------------
  imuldiv_mul_dpath mul_dpath (
    .clk   (clk),
    .reset (reset),
    .port  (mul_bus.dpath)
  );

  imuldiv_div_dpath div_dpath (
    .clk   (clk),
    .reset (reset),
    .port  (div_bus.dpath)
  );

endmodule

//--- tests/imuldiv_tb.sv
/* directed testbench for the multiply/divide unit over its Wishbone port.
   expected results come from a 64-bit software model of each operation */
`timescale 1ns/1ps

module imuldiv_tb;
  import imuldiv_pkg::*;

  // about 260 operations of roughly 45 cycles each, plus margin
  localparam int max_cycles = 20000;
  localparam int num_random = 40;

  logic  clk;
  logic  reset;
  logic  wb_cyc;
  logic  wb_stb;
  logic  wb_we;
  addr_t wb_adr;
  word_t wb_wdata;
  word_t wb_rdata;
  logic  wb_ack;
  int    errors;
  int    checks;
  int    cycles;
  word_t corners [5];

  imuldiv_top UUT (
    .clk      (clk),
    .reset    (reset),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_wdata (wb_wdata),
    .wb_rdata (wb_rdata),
    .wb_ack   (wb_ack)
  );

  // 100 ns period
  always #50 clk = ~clk;

  // run limit that catches a missing ack
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout: no ack or end of tests within %0d clock cycles", max_cycles);
      $display("test failed");
      $finish;
    end
  end

  // ----------------------------------------------------------
  // checking and reference model
  // ----------------------------------------------------------
  task automatic check(input string name, input logic [63:0] actual,
                       input logic [63:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, actual, expected);
    end
  endtask

  // product, or remainder in the high word and quotient in the low word
  function automatic dword_t model_result(input op_t op, input word_t a, input word_t b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic signed [63:0] sq;
    logic signed [63:0] sr;
    logic [63:0]        ua;
    logic [63:0]        ub;
    word_t              q;
    word_t              r;
    sa = {{32{a[31]}}, a};
    sb = {{32{b[31]}}, b};
    ua = {32'b0, a};
    ub = {32'b0, b};
    case (op)
      op_mul:  return sa * sb;
      op_mulu: return ua * ub;
      default: begin
        if (b == '0) begin
          // divide by zero gives all ones and the dividend
          q = '1;
          r = a;
        end else if (op == op_div) begin
          // truncating division with the remainder taking the dividend's sign
          sq = sa / sb;
          sr = sa % sb;
          q  = sq[31:0];
          r  = sr[31:0];
        end else begin
          q = word_t'(ua / ub);
          r = word_t'(ua % ub);
        end
        return {r, q};
      end
    endcase
  endfunction

  // ----------------------------------------------------------
  // bus tasks, inputs change on the falling edge
  // ----------------------------------------------------------
  task automatic wb_write(input addr_t adr, input word_t data);
    @(negedge clk);
    // ack of the previous transfer lasts a single cycle
    check("wb_ack", wb_ack, 1'b0);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = adr;
    wb_wdata = data;
    @(negedge clk);
    while (!wb_ack) @(negedge clk);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  // waits counts the cycles the slave held off ack
  task automatic wb_read(input addr_t adr, output word_t data, output int waits);
    @(negedge clk);
    check("wb_ack", wb_ack, 1'b0);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    waits  = 0;
    @(negedge clk);
    while (!wb_ack) begin
      waits++;
      @(negedge clk);
    end
    data   = wb_rdata;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  task automatic run_op(input op_t op, input word_t a, input word_t b);
    dword_t expected;
    word_t  lo;
    word_t  hi;
    int     waits;
    expected = model_result(op, a, b);
    wb_write(adr_a, a);
    wb_write(adr_b, b);
    wb_write(adr_cmd, word_t'(op));
    wb_read(adr_res_lo, lo, waits);
    wb_read(adr_res_hi, hi, waits);
    check($sformatf("res_lo op %0d a %h b %h", op, a, b), lo, expected[31:0]);
    check($sformatf("res_hi op %0d a %h b %h", op, a, b), hi, expected[63:32]);
  endtask

  // ----------------------------------------------------------
  // directed tests
  // ----------------------------------------------------------
  task automatic test_reset_values();
    word_t data;
    word_t a;
    word_t b;
    int    waits;
    wb_read(adr_status, data, waits);
    check("status", data, '0);
    wb_read(adr_a, data, waits);
    check("a", data, '0);
    wb_read(adr_b, data, waits);
    check("b", data, '0);
    wb_read(adr_res_lo, data, waits);
    check("res_lo", data, '0);
    wb_read(adr_res_hi, data, waits);
    check("res_hi", data, '0);
    // operand registers read back what was written
    a = $urandom();
    b = $urandom();
    wb_write(adr_a, a);
    wb_write(adr_b, b);
    wb_read(adr_a, data, waits);
    check("a", data, a);
    wb_read(adr_b, data, waits);
    check("b", data, b);
  endtask

  task automatic test_multiply();
    word_t a;
    word_t b;
    foreach (corners[i]) begin
      foreach (corners[j]) begin
        run_op(op_mul, corners[i], corners[j]);
        run_op(op_mulu, corners[i], corners[j]);
      end
    end
    for (int i = 0; i < num_random; i++) begin
      a = $urandom();
      b = $urandom();
      run_op(op_mul, a, b);
      run_op(op_mulu, a, b);
    end
  endtask

  task automatic test_divide();
    word_t a;
    word_t b;
    foreach (corners[i]) begin
      foreach (corners[j]) begin
        if (corners[j] != '0) begin
          run_op(op_div, corners[i], corners[j]);
          run_op(op_divu, corners[i], corners[j]);
        end
      end
    end
    // all four sign combinations with a nonzero remainder
    run_op(op_div, 32'sd7, 32'sd2);
    run_op(op_div, -32'sd7, 32'sd2);
    run_op(op_div, 32'sd7, -32'sd2);
    run_op(op_div, -32'sd7, -32'sd2);
    run_op(op_divu, 32'd100, 32'd7);
    for (int i = 0; i < num_random; i++) begin
      a = $urandom();
      // narrower divisors give quotients of many sizes
      b = $urandom() >> (i % 32);
      if (i % 2) b = -b;
      run_op(op_div, a, b);
      run_op(op_divu, a, b);
    end
  endtask

  task automatic test_divide_by_zero();
    word_t lo;
    word_t hi;
    int    waits;
    foreach (corners[i]) begin
      for (int s = 0; s < 2; s++) begin
        wb_write(adr_a, corners[i]);
        wb_write(adr_b, '0);
        wb_write(adr_cmd, (s == 0) ? word_t'(op_div) : word_t'(op_divu));
        wb_read(adr_res_lo, lo, waits);
        wb_read(adr_res_hi, hi, waits);
        check($sformatf("res_lo div0 a %h", corners[i]), lo, 32'hffff_ffff);
        check($sformatf("res_hi div0 a %h", corners[i]), hi, corners[i]);
      end
    end
  endtask

  task automatic test_busy();
    dword_t expected;
    word_t  a;
    word_t  b;
    word_t  data;
    int     waits;
    a        = 32'h1234_5678;
    b        = 32'hfedc_ba98;
    expected = model_result(op_mul, a, b);
    wb_write(adr_a, a);
    wb_write(adr_b, b);
    wb_write(adr_cmd, word_t'(op_mul));
    wb_read(adr_status, data, waits);
    check("status busy", data, 32'd1);
    // second command lands in st_calc and must be dropped
    wb_write(adr_cmd, word_t'(op_divu));
    wb_read(adr_res_lo, data, waits);
    check("res_lo stalled", waits > 1, 1'b1);
    check("res_lo", data, expected[31:0]);
    wb_read(adr_res_hi, data, waits);
    check("res_hi", data, expected[63:32]);
    wb_read(adr_status, data, waits);
    check("status done", data, '0);
  endtask

  initial begin
    clk      = 1'b0;
    reset    = 1'b1;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_wdata = '0;
    errors   = 0;
    checks   = 0;
    cycles   = 0;
    corners  = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
    void'($urandom(32'hc28cece9));
    repeat (16) @(negedge clk);
    reset = 1'b0;
    test_reset_values();
    test_multiply();
    test_divide();
    test_divide_by_zero();
    test_busy();
    $display("%0d errors in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule
